// ==== files.f ====
+incdir+.
i2cp_bus_pkg.sv
i2cp_reg_pkg.sv
i2cp_fifo.sv
i2cp_mailbox.sv
i2cp_irq.sv
i2cp_port.sv
i2cp_cfg_regs.sv
i2cp_bridge.sv
i2cp_bridge_assertions.sv
tb_i2cp_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= tb_i2cp_bridge
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_i2cp_bridge.sv ====
/*
  testbench for i2cp_bridge; rst is the clock, clk the active-high reset
  drives bus traffic for the shadow model of the bound checker
*/
`default_nettype none
`timescale 1ns/1ps
`include "i2cp_config.svh"

module tb_i2cp_bridge
  import i2cp_bus_pkg::*;
  import i2cp_reg_pkg::*;
();

  localparam int WAIT_LIMIT = 32;  // cycles per wait

  logic        rst;
  logic        clk;
  apb_req_t    apb;
  i2c_req_t    i2c;
  apb_data_t   apb_rdata;
  i2c_data_t   i2c_rdata;
  i2c_cfg_t    cfg;
  logic        i2c_irq;
  logic        apb_irq;
  logic [31:0] rnd;

  i2cp_bridge i_i2cp_bridge (
    .rst_i(rst), .clk_i(clk),
    .apb_i(apb), .apb_rdata_o(apb_rdata),
    .i2c_i(i2c), .i2c_rdata_o(i2c_rdata),
    .cfg_o(cfg), .i2c_irq_o(i2c_irq), .apb_irq_o(apb_irq)
  );

  initial begin
    rst = 1'b0;
    forever #4 rst = ~rst;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic step();
    @(posedge rst);
    #1;
  endtask

  task automatic apb_write(input logic [7:0] idx, input logic [31:0] data);
    apb.waddr = {2'b00, idx, 2'b00};
    apb.wdata = data;
    apb.wren  = 1'b1;
    step();
    apb.wren  = 1'b0;
  endtask

  // rd_done follows once rdata of the address has been latched
  task automatic apb_read(input logic [7:0] idx);
    apb.raddr   = {2'b00, idx, 2'b00};
    step();
    apb.rd_done = 1'b1;
    step();
    apb.rd_done = 1'b0;
    apb.raddr   = '0;
  endtask

  task automatic i2c_write(input logic [7:0] idx, input logic [7:0] data);
    i2c.addr  = idx;
    i2c.wdata = data;
    i2c.wren  = 1'b1;
    step();
    i2c.wren  = 1'b0;
    i2c.addr  = '0;
  endtask

  task automatic i2c_read(input logic [7:0] idx);
    i2c.addr    = idx;
    step();
    i2c.rd_done = 1'b1;
    step();
    i2c.rd_done = 1'b0;
    i2c.addr    = '0;
  endtask

  task automatic wait_irq(input logic apb_side, input logic level);
    int n;
    n = 0;
    while (((apb_side ? apb_irq : i2c_irq) != level) && (n < WAIT_LIMIT)) begin
      step();
      n++;
    end
    if ((apb_side ? apb_irq : i2c_irq) != level)
      abort_run($sformatf("timeout waiting for %s irq to reach %b",
                          apb_side ? "apb" : "i2c", level));
  endtask

  // forwards a checker flag before the assertion at the next edge
  always @(negedge rst) begin
    if (!clk && (i_i2cp_bridge.i_assertions.check_ok != 5'h1f))
      abort_run($sformatf("Mismatch at %0t: check_ok is %b, expected 11111",
                          $time, i_i2cp_bridge.i_assertions.check_ok));
  end

  initial begin
    clk = 1'b1;
    apb = '0;
    i2c = '0;
    rnd = 32'd12;
    repeat (8) @(posedge rst);
    #1 clk = 1'b0;
    step();

    // configuration, read back from both sides
    for (int i = 0; i < 5; i++) begin
      rnd = xorshift32(rnd);
      apb_write(8'(i), rnd);
      apb_read(8'(i));
      i2c_read(8'(i));
    end

    // mailbox apb to i2c
    i2c_write(`I2CP_IDX_IRQ_I2C_EN, 8'h01);
    rnd = xorshift32(rnd);
    apb_write(`I2CP_IDX_MSG_A2I, rnd);
    wait_irq(1'b0, 1'b1);
    i2c_read(`I2CP_IDX_MSG_A2I_ST);
    i2c_read(`I2CP_IDX_MSG_A2I);
    wait_irq(1'b0, 1'b0);
    apb_read(`I2CP_IDX_MSG_A2I_ST);

    // mailbox i2c to apb
    apb_write(`I2CP_IDX_IRQ_APB_EN, 32'h1);
    rnd = xorshift32(rnd);
    i2c_write(`I2CP_IDX_MSG_I2A, rnd[7:0]);
    wait_irq(1'b1, 1'b1);
    apb_read(`I2CP_IDX_MSG_I2A_ST);
    apb_read(`I2CP_IDX_MSG_I2A);
    wait_irq(1'b1, 1'b0);

    // i2c to apb fifo order
    apb_write(`I2CP_IDX_IRQ_APB_EN, 32'h2);
    for (int i = 0; i < 8; i++) begin
      rnd = xorshift32(rnd);
      i2c_write(`I2CP_IDX_FIFO_I2A_WR, rnd[7:0]);
    end
    wait_irq(1'b1, 1'b1);
    i2c_read(`I2CP_IDX_FIFO_I2A_RD);  // not the i2c receive port
    apb_read(`I2CP_IDX_FIFO_I2A_ST);
    repeat (8) apb_read(`I2CP_IDX_FIFO_I2A_RD);
    wait_irq(1'b1, 1'b0);

    // apb to i2c fifo, overfill then drain past empty
    i2c_write(`I2CP_IDX_IRQ_I2C_EN, 8'h07);
    wait_irq(1'b0, 1'b1);
    for (int i = 0; i < 17; i++) begin
      rnd = xorshift32(rnd);
      apb_write(`I2CP_IDX_FIFO_A2I_WR, rnd);
    end
    apb_read(`I2CP_IDX_FIFO_A2I_RD);  // not the apb receive port
    i2c_read(`I2CP_IDX_FIFO_A2I_ST);
    repeat (16) i2c_read(`I2CP_IDX_FIFO_A2I_RD);
    i2c_read(`I2CP_IDX_FIFO_A2I_ST);
    i2c_read(`I2CP_IDX_FIFO_A2I_RD);
    i2c_read(`I2CP_IDX_FIFO_A2I_ST);
    apb_read(`I2CP_IDX_FIFO_A2I_ST);

    // random enable masks on both sides
    for (int i = 0; i < 6; i++) begin
      rnd = xorshift32(rnd);
      apb_write(`I2CP_IDX_IRQ_APB_EN, rnd);
      i2c_write(`I2CP_IDX_IRQ_I2C_EN, rnd[15:8]);
      apb_read(`I2CP_IDX_IRQ_APB_ST);
      i2c_read(`I2CP_IDX_IRQ_I2C_ST);
    end

    step();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== i2cp_bridge_assertions.sv ====
/*
  checker bound into i2cp_bridge, keeps a shadow model of the register map
  built from the port traffic and compares every output at each clock
  a FIFO read port is undefined until its first push, in the model as in the RTL
*/
`default_nettype none
`timescale 1ns/1ps
`include "i2cp_config.svh"

module i2cp_bridge_assertions
  import i2cp_bus_pkg::*;
  import i2cp_reg_pkg::*;
(
  input wire            rst_i,
  input wire            clk_i,
  input wire apb_req_t  apb_i,
  input wire i2c_req_t  i2c_i,
  input wire apb_data_t apb_rdata_i,
  input wire i2c_data_t i2c_rdata_i,
  input wire i2c_cfg_t  cfg_i,
  input wire            i2c_irq_i,
  input wire            apb_irq_i
);

  i2c_cfg_t   m_cfg;
  logic [7:0] m_msg_a2i;
  logic [7:0] m_msg_i2a;
  logic       m_full_a2i;
  logic       m_full_i2a;
  logic [7:0] m_fifo_a2i [16];
  logic [7:0] m_fifo_i2a [16];
  logic [3:0] m_rp_a2i;
  logic [3:0] m_rp_i2a;
  logic [4:0] m_cnt_a2i;
  logic [4:0] m_cnt_i2a;
  irq_st_t    m_en_i2c;
  irq_st_t    m_en_apb;
  irq_st_t    src_i2c;
  irq_st_t    src_apb;
  apb_data_t  exp_apb_rd;
  logic [7:0] exp_i2c_rd;
  logic [4:0] check_ok;     // one bit per compared output
  logic       apb_wr;
  logic       apb_rok;
  logic       apb_done;
  logic [7:0] apb_widx;
  logic [7:0] apb_ridx;
  logic       a2i_push;
  logic       a2i_pop;
  logic       i2a_push;
  logic       i2a_pop;

  // apb words live in page 0 only
  assign apb_wr   = apb_i.wren && (apb_i.waddr[11:10] == 2'b00);
  assign apb_rok  = (apb_i.raddr[11:10] == 2'b00);
  assign apb_done = apb_i.rd_done && apb_rok;
  assign apb_widx = apb_i.waddr[9:2];
  assign apb_ridx = apb_i.raddr[9:2];

  assign a2i_push = apb_wr && (apb_widx == `I2CP_IDX_FIFO_A2I_WR) && (m_cnt_a2i != 5'd16);
  assign a2i_pop  = i2c_i.rd_done && (i2c_i.addr == `I2CP_IDX_FIFO_A2I_RD) && (m_cnt_a2i != 5'd0);
  assign i2a_push = i2c_i.wren && (i2c_i.addr == `I2CP_IDX_FIFO_I2A_WR) && (m_cnt_i2a != 5'd16);
  assign i2a_pop  = apb_done && (apb_ridx == `I2CP_IDX_FIFO_I2A_RD) && (m_cnt_i2a != 5'd0);

  assign src_i2c = '{tx_empty: (m_cnt_i2a == 5'd0), rx_nonempty: (m_cnt_a2i != 5'd0),
                     mbox_full: m_full_a2i};
  assign src_apb = '{tx_empty: (m_cnt_a2i == 5'd0), rx_nonempty: (m_cnt_i2a != 5'd0),
                     mbox_full: m_full_i2a};

  // expected byte of one register index as seen from one side
  function automatic logic [7:0] model_read(input logic [7:0] idx, input logic apb_side);
    case (idx)
      `I2CP_IDX_DEV_ADDR:    return {1'b0, m_cfg.dev_addr};
      `I2CP_IDX_ENABLE:      return {7'b0, m_cfg.enabled};
      `I2CP_IDX_DEBOUNCE:    return m_cfg.debounce;
      `I2CP_IDX_SCL:         return m_cfg.scl_delay;
      `I2CP_IDX_SDA:         return m_cfg.sda_delay;
      `I2CP_IDX_MSG_I2A:     return m_msg_i2a;
      `I2CP_IDX_MSG_I2A_ST:  return {7'b0, m_full_i2a};
      `I2CP_IDX_MSG_A2I:     return m_msg_a2i;
      `I2CP_IDX_MSG_A2I_ST:  return {7'b0, m_full_a2i};
      `I2CP_IDX_FIFO_I2A_RD: return apb_side ? m_fifo_i2a[m_rp_i2a] : 8'h00;
      `I2CP_IDX_FIFO_I2A_ST: return {6'b0, (m_cnt_i2a == 5'd16), (m_cnt_i2a == 5'd0)};
      `I2CP_IDX_FIFO_A2I_RD: return apb_side ? 8'h00 : m_fifo_a2i[m_rp_a2i];
      `I2CP_IDX_FIFO_A2I_ST: return {6'b0, (m_cnt_a2i == 5'd16), (m_cnt_a2i == 5'd0)};
      `I2CP_IDX_IRQ_I2C_ST:  return {5'b0, src_i2c & m_en_i2c};
      `I2CP_IDX_IRQ_I2C_EN:  return {5'b0, m_en_i2c};
      `I2CP_IDX_IRQ_APB_ST:  return {5'b0, src_apb & m_en_apb};
      `I2CP_IDX_IRQ_APB_EN:  return {5'b0, m_en_apb};
      default:               return 8'h00;
    endcase
  endfunction

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      m_cfg      <= '{`I2CP_DEF_DEV_ADDR, 1'b0, `I2CP_DEF_DEBOUNCE,
                      `I2CP_DEF_SCL_DELAY, `I2CP_DEF_SDA_DELAY};
      m_msg_a2i  <= '0;
      m_msg_i2a  <= '0;
      m_full_a2i <= 1'b0;
      m_full_i2a <= 1'b0;
      m_rp_a2i   <= '0;
      m_rp_i2a   <= '0;
      m_cnt_a2i  <= '0;
      m_cnt_i2a  <= '0;
      m_en_i2c   <= '0;
      m_en_apb   <= '0;
      exp_apb_rd <= '0;
      exp_i2c_rd <= '0;
    end else begin
      exp_apb_rd <= apb_rok ? {24'h0, model_read(apb_ridx, 1'b1)} : '0;
      exp_i2c_rd <= model_read(i2c_i.addr, 1'b0);
      if (apb_wr) begin
        case (apb_widx)
          `I2CP_IDX_DEV_ADDR:   m_cfg.dev_addr  <= apb_i.wdata[6:0];
          `I2CP_IDX_ENABLE:     m_cfg.enabled   <= apb_i.wdata[0];
          `I2CP_IDX_DEBOUNCE:   m_cfg.debounce  <= apb_i.wdata[7:0];
          `I2CP_IDX_SCL:        m_cfg.scl_delay <= apb_i.wdata[7:0];
          `I2CP_IDX_SDA:        m_cfg.sda_delay <= apb_i.wdata[7:0];
          `I2CP_IDX_IRQ_APB_EN: m_en_apb        <= irq_st_t'(apb_i.wdata[2:0]);
          default:              ;
        endcase
      end
      if (i2c_i.wren && (i2c_i.addr == `I2CP_IDX_IRQ_I2C_EN))
        m_en_i2c <= irq_st_t'(i2c_i.wdata[2:0]);
      // a write in the same cycle overrides the clear
      if (i2c_i.rd_done && (i2c_i.addr == `I2CP_IDX_MSG_A2I)) m_full_a2i <= 1'b0;
      if (apb_wr && (apb_widx == `I2CP_IDX_MSG_A2I)) begin
        m_msg_a2i  <= apb_i.wdata[7:0];
        m_full_a2i <= 1'b1;
      end
      if (apb_done && (apb_ridx == `I2CP_IDX_MSG_I2A)) m_full_i2a <= 1'b0;
      if (i2c_i.wren && (i2c_i.addr == `I2CP_IDX_MSG_I2A)) begin
        m_msg_i2a  <= i2c_i.wdata;
        m_full_i2a <= 1'b1;
      end
      if (a2i_push) m_fifo_a2i[m_rp_a2i + m_cnt_a2i[3:0]] <= apb_i.wdata[7:0];
      if (a2i_pop) m_rp_a2i <= m_rp_a2i + 4'd1;
      m_cnt_a2i <= m_cnt_a2i + {4'b0, a2i_push} - {4'b0, a2i_pop};
      if (i2a_push) m_fifo_i2a[m_rp_i2a + m_cnt_i2a[3:0]] <= i2c_i.wdata;
      if (i2a_pop) m_rp_i2a <= m_rp_i2a + 4'd1;
      m_cnt_i2a <= m_cnt_i2a + {4'b0, i2a_push} - {4'b0, i2a_pop};
    end
  end

  assign check_ok[0] = (cfg_i == m_cfg);
  assign check_ok[1] = (i2c_irq_i == |(src_i2c & m_en_i2c));
  assign check_ok[2] = (apb_irq_i == |(src_apb & m_en_apb));
  assign check_ok[3] = (apb_rdata_i == exp_apb_rd);
  assign check_ok[4] = (i2c_rdata_i == exp_i2c_rd);

  a_cfg: assert property (@(posedge rst_i) disable iff (clk_i) check_ok[0])
    else $error("cfg_o differs from the configuration model");
  a_i2c_irq: assert property (@(posedge rst_i) disable iff (clk_i) check_ok[1])
    else $error("i2c_irq_o differs from masked model sources");
  a_apb_irq: assert property (@(posedge rst_i) disable iff (clk_i) check_ok[2])
    else $error("apb_irq_o differs from masked model sources");
  a_apb_rd: assert property (@(posedge rst_i) disable iff (clk_i) check_ok[3])
    else $error("apb_rdata_o differs from the model read");
  a_i2c_rd: assert property (@(posedge rst_i) disable iff (clk_i) check_ok[4])
    else $error("i2c_rdata_o differs from the model read");

endmodule

bind i2cp_bridge i2cp_bridge_assertions i_assertions (
  .rst_i(rst_i), .clk_i(clk_i), .apb_i(apb_i), .i2c_i(i2c_i),
  .apb_rdata_i(apb_rdata_o), .i2c_rdata_i(i2c_rdata_o), .cfg_i(cfg_o),
  .i2c_irq_i(i2c_irq_o), .apb_irq_i(apb_irq_o)
);

`default_nettype wire

// ==== i2cp_bridge.sv ====
/*
  register bridge between an apb-side host and an i2c target
  rst_i is the clock, clk_i the asynchronous active-high reset
  apb reads with bits 11:10 set return zero and have no side effect
*/
`default_nettype none
`timescale 1ns/1ps
`include "i2cp_config.svh"

module i2cp_bridge
  import i2cp_bus_pkg::*;
  import i2cp_reg_pkg::*;
(
  input  wire           rst_i,
  input  wire           clk_i,
  input  wire apb_req_t apb_i,
  output apb_data_t     apb_rdata_o,
  input  wire i2c_req_t i2c_i,
  output i2c_data_t     i2c_rdata_o,
  output i2c_cfg_t      cfg_o,
  output logic          i2c_irq_o,
  output logic          apb_irq_o
);

  reg_acc_t   apb_acc;
  reg_acc_t   i2c_acc;
  reg_view_t  view;
  logic [7:0] msg_i2a;
  logic       msg_i2a_full;
  logic [7:0] msg_a2i;
  logic       msg_a2i_full;
  logic [7:0] i2a_head;
  logic       i2a_full;
  logic       i2a_empty;
  logic [7:0] a2i_head;
  logic       a2i_full;
  logic       a2i_empty;
  irq_st_t    i2c_src;
  irq_st_t    i2c_en;
  irq_st_t    i2c_st;
  irq_st_t    apb_src;
  irq_st_t    apb_en;
  irq_st_t    apb_st;

  i2cp_port #(
    .addr_t(apb_addr_t), .data_t(apb_data_t), .RX_IDX(`I2CP_IDX_FIFO_I2A_RD)
  ) i_apb_port (
    .rst_i, .clk_i,
    .waddr_i(apb_i.waddr), .raddr_i(apb_i.raddr), .wdata_i(apb_i.wdata),
    .wren_i(apb_i.wren), .rd_done_i(apb_i.rd_done),
    .view_i(view), .acc_o(apb_acc), .rdata_o(apb_rdata_o)
  );

  i2cp_port #(
    .addr_t(i2c_addr_t), .data_t(i2c_data_t), .RX_IDX(`I2CP_IDX_FIFO_A2I_RD)
  ) i_i2c_port (
    .rst_i, .clk_i,
    .waddr_i(i2c_i.addr), .raddr_i(i2c_i.addr), .wdata_i(i2c_i.wdata),  // one address for both
    .wren_i(i2c_i.wren), .rd_done_i(i2c_i.rd_done),
    .view_i(view), .acc_o(i2c_acc), .rdata_o(i2c_rdata_o)
  );

  i2cp_cfg_regs i_cfg_regs (.rst_i, .clk_i, .acc_i(apb_acc), .cfg_o(cfg_o));

  i2cp_mailbox #(.WR_IDX(`I2CP_IDX_MSG_I2A), .RD_IDX(`I2CP_IDX_MSG_I2A)) i_mbox_i2a (
    .rst_i, .clk_i, .wr_acc_i(i2c_acc), .rd_acc_i(apb_acc),
    .data_o(msg_i2a), .full_o(msg_i2a_full)
  );

  i2cp_mailbox #(.WR_IDX(`I2CP_IDX_MSG_A2I), .RD_IDX(`I2CP_IDX_MSG_A2I)) i_mbox_a2i (
    .rst_i, .clk_i, .wr_acc_i(apb_acc), .rd_acc_i(i2c_acc),
    .data_o(msg_a2i), .full_o(msg_a2i_full)
  );

  // i2c pushes, apb pops
  i2cp_fifo #(.DEPTH_W(`I2CP_FIFO_DEPTH_W)) i_fifo_i2a (
    .rst_i, .clk_i,
    .push_i(i2c_acc.wr && (i2c_acc.widx == `I2CP_IDX_FIFO_I2A_WR)),
    .wdata_i(i2c_acc.wbyte),
    .pop_i(apb_acc.rd_done && (apb_acc.ridx == `I2CP_IDX_FIFO_I2A_RD)),
    .rdata_o(i2a_head), .full_o(i2a_full), .empty_o(i2a_empty)
  );

  // apb pushes, i2c pops
  i2cp_fifo #(.DEPTH_W(`I2CP_FIFO_DEPTH_W)) i_fifo_a2i (
    .rst_i, .clk_i,
    .push_i(apb_acc.wr && (apb_acc.widx == `I2CP_IDX_FIFO_A2I_WR)),
    .wdata_i(apb_acc.wbyte),
    .pop_i(i2c_acc.rd_done && (i2c_acc.ridx == `I2CP_IDX_FIFO_A2I_RD)),
    .rdata_o(a2i_head), .full_o(a2i_full), .empty_o(a2i_empty)
  );

  // each side sees its incoming mailbox, its rx fifo and its tx fifo
  assign i2c_src = '{tx_empty: i2a_empty, rx_nonempty: !a2i_empty, mbox_full: msg_a2i_full};
  assign apb_src = '{tx_empty: a2i_empty, rx_nonempty: !i2a_empty, mbox_full: msg_i2a_full};

  i2cp_irq #(.EN_IDX(`I2CP_IDX_IRQ_I2C_EN)) i_irq_i2c (
    .rst_i, .clk_i, .acc_i(i2c_acc), .src_i(i2c_src),
    .enable_o(i2c_en), .status_o(i2c_st), .irq_o(i2c_irq_o)
  );

  i2cp_irq #(.EN_IDX(`I2CP_IDX_IRQ_APB_EN)) i_irq_apb (
    .rst_i, .clk_i, .acc_i(apb_acc), .src_i(apb_src),
    .enable_o(apb_en), .status_o(apb_st), .irq_o(apb_irq_o)
  );

  always_comb begin
    view.cfg          = cfg_o;
    view.msg_i2a      = msg_i2a;
    view.msg_i2a_full = msg_i2a_full;
    view.msg_a2i      = msg_a2i;
    view.msg_a2i_full = msg_a2i_full;
    view.i2a_head     = i2a_head;
    view.a2i_head     = a2i_head;
    view.i2a_full     = i2a_full;
    view.i2a_empty    = i2a_empty;
    view.a2i_full     = a2i_full;
    view.a2i_empty    = a2i_empty;
    view.i2c_irq_st   = i2c_st;
    view.i2c_irq_en   = i2c_en;
    view.apb_irq_st   = apb_st;
    view.apb_irq_en   = apb_en;
  end

endmodule

`default_nettype wire

// ==== i2cp_cfg_regs.sv ====
/*
  i2c configuration registers, written from the apb side only
  each register keeps only its own width of the written byte
*/
`default_nettype none
`timescale 1ns/1ps
`include "i2cp_config.svh"

module i2cp_cfg_regs
  import i2cp_bus_pkg::*;
  import i2cp_reg_pkg::*;
(
  input  wire           rst_i,
  input  wire           clk_i,
  input  wire reg_acc_t acc_i,
  output i2c_cfg_t      cfg_o
);

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      cfg_o.dev_addr  <= `I2CP_DEF_DEV_ADDR;
      cfg_o.enabled   <= 1'b0;             // target stays off until enabled
      cfg_o.debounce  <= `I2CP_DEF_DEBOUNCE;
      cfg_o.scl_delay <= `I2CP_DEF_SCL_DELAY;
      cfg_o.sda_delay <= `I2CP_DEF_SDA_DELAY;
    end else if (acc_i.wr) begin
      case (acc_i.widx)
        `I2CP_IDX_DEV_ADDR: cfg_o.dev_addr  <= acc_i.wbyte[6:0];
        `I2CP_IDX_ENABLE:   cfg_o.enabled   <= acc_i.wbyte[0];
        `I2CP_IDX_DEBOUNCE: cfg_o.debounce  <= acc_i.wbyte;
        `I2CP_IDX_SCL:      cfg_o.scl_delay <= acc_i.wbyte;
        `I2CP_IDX_SDA:      cfg_o.sda_delay <= acc_i.wbyte;
        default:            ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== i2cp_port.sv ====
/*
  address decode and registered read mux of one side
  addresses wider than 8 bits need bits above 9 at zero and index by word
  rdata lags the read address by one clock; rst_i clocks, clk_i resets
*/
`default_nettype none
`timescale 1ns/1ps
`include "i2cp_config.svh"

module i2cp_port
  import i2cp_bus_pkg::*;
  import i2cp_reg_pkg::*;
#(
  parameter type        addr_t = logic [7:0],
  parameter type        data_t = logic [7:0],
  parameter logic [7:0] RX_IDX = `I2CP_IDX_FIFO_A2I_RD  // own fifo read port
) (
  input  wire            rst_i,
  input  wire            clk_i,
  input  wire addr_t     waddr_i,
  input  wire addr_t     raddr_i,
  input  wire data_t     wdata_i,
  input  wire            wren_i,
  input  wire            rd_done_i,
  input  wire reg_view_t view_i,
  output reg_acc_t       acc_o,
  output data_t          rdata_o
);

  localparam int AW = $bits(addr_t);

  logic       wr_ok;
  logic       rd_ok;
  logic [7:0] widx;
  logic [7:0] ridx;
  logic [7:0] rbyte;

  if (AW > 8) begin : g_paged
    assign wr_ok = (waddr_i[AW-1:10] == '0);  // page 0 only
    assign rd_ok = (raddr_i[AW-1:10] == '0);
    assign widx  = waddr_i[9:2];
    assign ridx  = raddr_i[9:2];
  end else begin : g_flat
    assign wr_ok = 1'b1;
    assign rd_ok = 1'b1;
    assign widx  = waddr_i[7:0];
    assign ridx  = raddr_i[7:0];
  end

  always_comb begin
    acc_o.wr      = wren_i && wr_ok;
    acc_o.widx    = widx;
    acc_o.wbyte   = wdata_i[7:0];
    acc_o.rd_done = rd_done_i && rd_ok;
    acc_o.ridx    = ridx;
  end

  always_comb begin
    case (ridx)
      `I2CP_IDX_DEV_ADDR:    rbyte = {1'b0, view_i.cfg.dev_addr};
      `I2CP_IDX_ENABLE:      rbyte = {7'b0, view_i.cfg.enabled};
      `I2CP_IDX_DEBOUNCE:    rbyte = view_i.cfg.debounce;
      `I2CP_IDX_SCL:         rbyte = view_i.cfg.scl_delay;
      `I2CP_IDX_SDA:         rbyte = view_i.cfg.sda_delay;
      `I2CP_IDX_MSG_I2A:     rbyte = view_i.msg_i2a;
      `I2CP_IDX_MSG_I2A_ST:  rbyte = {7'b0, view_i.msg_i2a_full};
      `I2CP_IDX_MSG_A2I:     rbyte = view_i.msg_a2i;
      `I2CP_IDX_MSG_A2I_ST:  rbyte = {7'b0, view_i.msg_a2i_full};
      `I2CP_IDX_FIFO_I2A_RD: rbyte = (RX_IDX == `I2CP_IDX_FIFO_I2A_RD) ? view_i.i2a_head : 8'h00;
      `I2CP_IDX_FIFO_I2A_ST: rbyte = {6'b0, view_i.i2a_full, view_i.i2a_empty};
      `I2CP_IDX_FIFO_A2I_RD: rbyte = (RX_IDX == `I2CP_IDX_FIFO_A2I_RD) ? view_i.a2i_head : 8'h00;
      `I2CP_IDX_FIFO_A2I_ST: rbyte = {6'b0, view_i.a2i_full, view_i.a2i_empty};
      `I2CP_IDX_IRQ_I2C_ST:  rbyte = {5'b0, view_i.i2c_irq_st};
      `I2CP_IDX_IRQ_I2C_EN:  rbyte = {5'b0, view_i.i2c_irq_en};
      `I2CP_IDX_IRQ_APB_ST:  rbyte = {5'b0, view_i.apb_irq_st};
      `I2CP_IDX_IRQ_APB_EN:  rbyte = {5'b0, view_i.apb_irq_en};
      default:               rbyte = 8'h00;  // fifo write ports read as zero too
    endcase
  end

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      rdata_o <= '0;
    end else begin
      rdata_o <= data_t'(rd_ok ? rbyte : 8'h00);  // zero extended
    end
  end

endmodule

`default_nettype wire

// ==== i2cp_irq.sv ====
/*
  interrupt enable register of one side
  irq_o is combinational from registered sources and enables
*/
`default_nettype none
`timescale 1ns/1ps

module i2cp_irq
  import i2cp_bus_pkg::*;
  import i2cp_reg_pkg::*;
#(
  parameter logic [7:0] EN_IDX = 8'h41
) (
  input  wire           rst_i,
  input  wire           clk_i,
  input  wire reg_acc_t acc_i,     // own side only
  input  wire irq_st_t  src_i,
  output irq_st_t       enable_o,
  output irq_st_t       status_o,
  output logic          irq_o
);

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      enable_o <= '0;
    end else if (acc_i.wr && (acc_i.widx == EN_IDX)) begin
      enable_o <= irq_st_t'(acc_i.wbyte[2:0]);
    end
  end

  assign status_o = irq_st_t'(src_i & enable_o);  // masked sources
  assign irq_o    = |status_o;

endmodule

`default_nettype wire

// ==== i2cp_mailbox.sv ====
/*
  single-byte message register with a full flag
  a write in the same cycle as the clearing read keeps the flag set
*/
`default_nettype none
`timescale 1ns/1ps

module i2cp_mailbox
  import i2cp_bus_pkg::*;
#(
  parameter logic [7:0] WR_IDX = 8'h10,
  parameter logic [7:0] RD_IDX = 8'h10
) (
  input  wire             rst_i,
  input  wire             clk_i,
  input  wire reg_acc_t   wr_acc_i,  // writing side
  input  wire reg_acc_t   rd_acc_i,  // reading side
  output logic      [7:0] data_o,
  output logic            full_o
);

  logic wr_hit;
  logic rd_hit;

  assign wr_hit = wr_acc_i.wr && (wr_acc_i.widx == WR_IDX);
  assign rd_hit = rd_acc_i.rd_done && (rd_acc_i.ridx == RD_IDX);

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      data_o <= '0;
      full_o <= 1'b0;
    end else if (wr_hit) begin
      data_o <= wr_acc_i.wbyte;
      full_o <= 1'b1;
    end else if (rd_hit) begin
      full_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== i2cp_fifo.sv ====
/*
  byte FIFO, first word fall through, 2**DEPTH_W entries
  push when full and pop when empty are dropped silently
  rst_i is the clock, clk_i the asynchronous active-high reset
*/
`default_nettype none
`timescale 1ns/1ps

module i2cp_fifo #(
  parameter int DEPTH_W = 4
) (
  input  wire        rst_i,
  input  wire        clk_i,
  input  wire        push_i,
  input  wire  [7:0] wdata_i,
  input  wire        pop_i,
  output logic [7:0] rdata_o,
  output logic       full_o,
  output logic       empty_o
);

  localparam int DEPTH = 1 << DEPTH_W;

  logic [7:0]         mem [DEPTH];
  logic [DEPTH_W-1:0] wr_ptr;
  logic [DEPTH_W-1:0] rd_ptr;
  logic [DEPTH_W:0]   count;
  logic               do_push;
  logic               do_pop;

  assign full_o  = count[DEPTH_W];  // msb only set at DEPTH
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign rdata_o = mem[rd_ptr];

  always_ff @(posedge rst_i) begin
    if (do_push) mem[wr_ptr] <= wdata_i;
  end

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;  // head moves after this edge
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== i2cp_reg_pkg.sv ====
/*
  types of the shared register map: configuration, interrupt status
  and the flat view that both read muxes select from
*/
`default_nettype none

package i2cp_reg_pkg;

  typedef struct packed {
    logic [6:0] dev_addr;
    logic       enabled;
    logic [7:0] debounce;
    logic [7:0] scl_delay;
    logic [7:0] sda_delay;
  } i2c_cfg_t;

  // bit 0 mbox_full, bit 1 rx_nonempty, bit 2 tx_empty
  typedef struct packed {
    logic tx_empty;
    logic rx_nonempty;
    logic mbox_full;
  } irq_st_t;

  typedef struct packed {
    i2c_cfg_t   cfg;
    logic [7:0] msg_i2a;
    logic       msg_i2a_full;
    logic [7:0] msg_a2i;
    logic       msg_a2i_full;
    logic [7:0] i2a_head;      // fifo heads, first word fall through
    logic [7:0] a2i_head;
    logic       i2a_full;
    logic       i2a_empty;
    logic       a2i_full;
    logic       a2i_empty;
    irq_st_t    i2c_irq_st;
    irq_st_t    i2c_irq_en;
    irq_st_t    apb_irq_st;
    irq_st_t    apb_irq_en;
  } reg_view_t;

endpackage

`default_nettype wire

// ==== i2cp_bus_pkg.sv ====
/*
  request structs of the two register ports and their decoded form
  apb addresses are byte addresses of 32-bit words
*/
`default_nettype none

package i2cp_bus_pkg;

  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;
  typedef logic [7:0]  i2c_addr_t;
  typedef logic [7:0]  i2c_data_t;

  typedef struct packed {
    apb_addr_t waddr;
    apb_data_t wdata;
    logic      wren;
    apb_addr_t raddr;
    logic      rd_done;  // host has sampled rdata of raddr
  } apb_req_t;

  typedef struct packed {
    i2c_addr_t addr;     // shared by writes and reads
    i2c_data_t wdata;
    logic      wren;
    logic      rd_done;
  } i2c_req_t;

  // one side's access after decode
  typedef struct packed {
    logic       wr;
    logic [7:0] widx;
    logic [7:0] wbyte;
    logic       rd_done;
    logic [7:0] ridx;
  } reg_acc_t;

endpackage

`default_nettype wire

// ==== i2cp_config.svh ====
/*
  reset defaults, FIFO depth and register indices of the bridge
  indices are byte offsets on the i2c side; apb addresses them as words
*/
`ifndef I2CP_CONFIG_SVH
`define I2CP_CONFIG_SVH

// reset values of the i2c configuration
`define I2CP_DEF_DEV_ADDR   7'h6F
`define I2CP_DEF_DEBOUNCE   8'd20
`define I2CP_DEF_SCL_DELAY  8'd20
`define I2CP_DEF_SDA_DELAY  8'd8

`define I2CP_FIFO_DEPTH_W   4        // 16 entries per direction

`define I2CP_IDX_DEV_ADDR     8'h00
`define I2CP_IDX_ENABLE       8'h01
`define I2CP_IDX_DEBOUNCE     8'h02
`define I2CP_IDX_SCL          8'h03
`define I2CP_IDX_SDA          8'h04
`define I2CP_IDX_MSG_I2A      8'h10
`define I2CP_IDX_MSG_I2A_ST   8'h11
`define I2CP_IDX_MSG_A2I      8'h12
`define I2CP_IDX_MSG_A2I_ST   8'h13
`define I2CP_IDX_FIFO_I2A_WR  8'h20
`define I2CP_IDX_FIFO_I2A_RD  8'h21
`define I2CP_IDX_FIFO_I2A_ST  8'h23  // {full, empty}
`define I2CP_IDX_FIFO_A2I_WR  8'h30
`define I2CP_IDX_FIFO_A2I_RD  8'h31
`define I2CP_IDX_FIFO_A2I_ST  8'h33  // {full, empty}
`define I2CP_IDX_IRQ_I2C_ST   8'h40
`define I2CP_IDX_IRQ_I2C_EN   8'h41
`define I2CP_IDX_IRQ_APB_ST   8'h50
`define I2CP_IDX_IRQ_APB_EN   8'h51

`endif
